/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_tail -f rv_tail.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram import rv_tail_pkg::*; #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_AW    = 8
) (
    input  logic              wb_clk,
    input  logic              en,
    input  logic              we,
    input  byte_en_t          byte_en,
    input  logic [RAM_AW-1:0] addr,
    input  word_t             wdata,
    output word_t             rdata
);

    word_t mem [RAM_WORDS];

    // one access per cycle; a write leaves rdata untouched.
    always_ff @(posedge wb_clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* mem_access.sv */
`timescale 1ns/1ps

module mem_access import rv_tail_pkg::*; #(
    parameter int RAM_AW = 8
) (
    input  logic              wb_clk,
    input  logic              wb_rst,
    input  logic              ex_valid,
    output logic              ex_ready,
    input  opcode_t           ex_opcode,
    input  funct_t            ex_funct,
    input  reg_addr_t         ex_rd_addr,
    input  logic              ex_we_rd,
    input  word_t             ex_result,
    input  word_t             ex_store_data,
    input  pc_t               ex_pc,
    input  logic              ex_change_pc,
    input  logic              flush,
    output logic              ram_en,
    output logic              ram_we,
    output byte_en_t          ram_byte_en,
    output logic [RAM_AW-1:0] ram_addr,
    output word_t             ram_wdata,
    input  word_t             ram_rdata,
    output logic              mem_ce,
    input  logic              wb_stall,
    output opcode_t           mem_opcode,
    output funct_t            mem_funct,
    output reg_addr_t         mem_rd_addr,
    output logic              mem_we_rd,
    output word_t             mem_rd_data,
    output pc_t               mem_pc,
    output logic              mem_change_pc,
    output word_t             mem_load_data
);

    mem_state_t state;
    logic       acc_valid;
    logic       accept;
    logic       is_load;
    logic       is_store;
    logic [1:0] byte_off;
    logic [4:0] shamt;
    word_t      st_data;
    word_t      held_rdata;
    word_t      raw_rdata;
    word_t      shifted;
    logic       in_mem_op;
    logic       in_aligned;

    // one instruction at a time; a new one enters as the old one leaves.
    assign mem_ce   = (state == MEM_WAIT_WB) || (state == MEM_HOLD);
    assign ex_ready = !flush && !acc_valid && (!mem_ce || !wb_stall);
    assign accept   = ex_valid && ex_ready;

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            state     <= MEM_IDLE;
            acc_valid <= 1'b0;
        end else if (flush) begin
            state     <= MEM_IDLE;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= accept;
            case (state)
                MEM_IDLE:    if (acc_valid) state <= MEM_WAIT_WB;
                MEM_WAIT_WB: state <= wb_stall ? MEM_HOLD : MEM_IDLE;
                MEM_HOLD:    if (!wb_stall) state <= MEM_IDLE;
                default:     state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk) begin
        if (accept) begin
            mem_opcode    <= ex_opcode;
            mem_funct     <= ex_funct;
            mem_rd_addr   <= ex_rd_addr;
            mem_we_rd     <= ex_we_rd;
            mem_rd_data   <= ex_result;
            mem_pc        <= ex_pc;
            mem_change_pc <= ex_change_pc;
            st_data       <= ex_store_data;
        end
        // park read data so the load is not issued twice.
        if (state == MEM_WAIT_WB && wb_stall) begin
            held_rdata <= ram_rdata;
        end
    end

    // --------------------
    // RAM access, one cycle after acceptance.
    // --------------------
    assign is_load  = mem_opcode[OP_LOAD];
    assign is_store = mem_opcode[OP_STORE];
    assign byte_off = mem_rd_data[1:0];
    assign shamt    = {byte_off, 3'b000};

    assign ram_en    = acc_valid && !flush && (is_load || is_store);
    assign ram_we    = acc_valid && !flush && is_store;
    assign ram_addr  = mem_rd_data[RAM_AW+1:2];
    assign ram_wdata = st_data << shamt;

    always_comb begin
        case (mem_funct)
            F3_B:    ram_byte_en = 4'b0001 << byte_off;
            F3_H:    ram_byte_en = 4'b0011 << byte_off;
            default: ram_byte_en = 4'b1111;
        endcase
    end

    // --------------------
    // load alignment and extension.
    // --------------------
    assign raw_rdata = (state == MEM_HOLD) ? held_rdata : ram_rdata;
    assign shifted   = raw_rdata >> shamt;

    always_comb begin
        case (mem_funct)
            F3_B:    mem_load_data = {{24{shifted[7]}}, shifted[7:0]};
            F3_H:    mem_load_data = {{16{shifted[15]}}, shifted[15:0]};
            F3_BU:   mem_load_data = {24'd0, shifted[7:0]};
            F3_HU:   mem_load_data = {16'd0, shifted[15:0]};
            default: mem_load_data = shifted;
        endcase
    end

    assign in_mem_op = ex_opcode[OP_LOAD] || ex_opcode[OP_STORE];

    always_comb begin
        case (ex_funct)
            F3_H, F3_HU: in_aligned = !ex_result[0];
            F3_W:        in_aligned = (ex_result[1:0] == 2'b00);
            default:     in_aligned = 1'b1;
        endcase
    end

    // execute must not hand over a misaligned access.
    a_aligned: assert property (@(posedge wb_clk) disable iff (!wb_rst)
        (accept && in_mem_op) |-> in_aligned)
        else $error("mem_access: misaligned access, pc %h addr %h", ex_pc, ex_result);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_tail_pkg::*; (
    input  logic      wb_clk,
    input  logic      wb_rst,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [32];

    // x0 is cleared by reset and never written.
    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && (rf_waddr != 5'd0)) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // --------------------
    // read ports.
    // --------------------
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* rv_tail.f */
rv_tail_pkg.sv
data_ram.sv
mem_access.sv
write_back.sv
reg_file.sv
rv_tail_top.sv
tb_checker.sv
tb_rv_tail.sv

/* rv_tail_pkg.sv */
package rv_tail_pkg;

    // --------------------
    // widths and vector types.
    // --------------------
    localparam int XLEN         = 32;
    localparam int OPCODE_WIDTH = 11;

    typedef logic [XLEN-1:0]         word_t;
    typedef logic [31:0]             pc_t;
    typedef logic [4:0]              reg_addr_t;
    typedef logic [2:0]              funct_t;
    typedef logic [OPCODE_WIDTH-1:0] opcode_t;
    typedef logic [3:0]              byte_en_t;

    // --------------------
    // one-hot opcode bit positions.
    // --------------------
    localparam int OP_RTYPE  = 0;
    localparam int OP_ITYPE  = 1;
    localparam int OP_LOAD   = 2;
    localparam int OP_STORE  = 3;
    localparam int OP_BRANCH = 4;
    localparam int OP_JAL    = 5;
    localparam int OP_JALR   = 6;
    localparam int OP_LUI    = 7;
    localparam int OP_AUIPC  = 8;
    localparam int OP_SYSTEM = 9;
    localparam int OP_FENCE  = 10;

    // --------------------
    // funct3 width codes for loads and stores.
    // --------------------
    localparam funct_t F3_B  = 3'b000;
    localparam funct_t F3_H  = 3'b001;
    localparam funct_t F3_W  = 3'b010;
    localparam funct_t F3_BU = 3'b100;
    localparam funct_t F3_HU = 3'b101;

    // memory stage output state.
    // idle: output empty; wait_wb: fresh RAM data; hold: data parked locally.
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT_WB,
        MEM_HOLD
    } mem_state_t;

endpackage

/* rv_tail_top.sv */
`timescale 1ns/1ps

module rv_tail_top import rv_tail_pkg::*; #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_AW    = 8
) (
    input  logic      wb_clk,
    input  logic      wb_rst,
    input  logic      ex_valid,
    output logic      ex_ready,
    input  opcode_t   ex_opcode,
    input  funct_t    ex_funct,
    input  reg_addr_t ex_rd_addr,
    input  logic      ex_we_rd,
    input  word_t     ex_result,
    input  word_t     ex_store_data,
    input  pc_t       ex_pc,
    input  logic      ex_change_pc,
    input  logic      hold,
    input  logic      flush,
    output logic      retire_valid,
    output reg_addr_t retire_rd_addr,
    output word_t     retire_rd_data,
    output pc_t       next_pc,
    output logic      change_pc,
    output logic      flush_out,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    // --------------------
    // RAM port.
    // --------------------
    logic              ram_en;
    logic              ram_we;
    byte_en_t          ram_byte_en;
    logic [RAM_AW-1:0] ram_addr;
    word_t             ram_wdata;
    word_t             ram_rdata;

    // --------------------
    // memory stage to write back.
    // --------------------
    logic      mem_ce;
    logic      wb_stall;
    opcode_t   mem_opcode;
    funct_t    mem_funct;
    reg_addr_t mem_rd_addr;
    logic      mem_we_rd;
    word_t     mem_rd_data;
    pc_t       mem_pc;
    logic      mem_change_pc;
    word_t     mem_load_data;

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    mem_access #(
        .RAM_AW(RAM_AW)
    ) u_mem_access (
        .wb_clk        (wb_clk),
        .wb_rst        (wb_rst),
        .ex_valid      (ex_valid),
        .ex_ready      (ex_ready),
        .ex_opcode     (ex_opcode),
        .ex_funct      (ex_funct),
        .ex_rd_addr    (ex_rd_addr),
        .ex_we_rd      (ex_we_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_pc         (ex_pc),
        .ex_change_pc  (ex_change_pc),
        .flush         (flush),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_byte_en   (ram_byte_en),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata),
        .mem_ce        (mem_ce),
        .wb_stall      (wb_stall),
        .mem_opcode    (mem_opcode),
        .mem_funct     (mem_funct),
        .mem_rd_addr   (mem_rd_addr),
        .mem_we_rd     (mem_we_rd),
        .mem_rd_data   (mem_rd_data),
        .mem_pc        (mem_pc),
        .mem_change_pc (mem_change_pc),
        .mem_load_data (mem_load_data)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS),
        .RAM_AW   (RAM_AW)
    ) u_data_ram (
        .wb_clk  (wb_clk),
        .en      (ram_en),
        .we      (ram_we),
        .byte_en (ram_byte_en),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

    write_back u_write_back (
        .wb_clk         (wb_clk),
        .wb_rst         (wb_rst),
        .mem_ce         (mem_ce),
        .wb_stall       (wb_stall),
        .mem_opcode     (mem_opcode),
        .mem_funct      (mem_funct),
        .mem_rd_addr    (mem_rd_addr),
        .mem_we_rd      (mem_we_rd),
        .mem_rd_data    (mem_rd_data),
        .mem_pc         (mem_pc),
        .mem_change_pc  (mem_change_pc),
        .mem_load_data  (mem_load_data),
        .hold           (hold),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .retire_rd_addr (retire_rd_addr),
        .retire_rd_data (retire_rd_data),
        .next_pc        (next_pc),
        .change_pc      (change_pc),
        .flush_out      (flush_out),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata)
    );

    reg_file u_reg_file (
        .wb_clk   (wb_clk),
        .wb_rst   (wb_rst),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import rv_tail_pkg::*; (
    input  logic      wb_clk,
    input  logic      wb_rst,
    input  logic      ex_valid,
    input  logic      ex_ready,
    input  opcode_t   ex_opcode,
    input  funct_t    ex_funct,
    input  reg_addr_t ex_rd_addr,
    input  logic      ex_we_rd,
    input  word_t     ex_result,
    input  word_t     ex_store_data,
    input  pc_t       ex_pc,
    input  logic      ex_change_pc,
    input  logic      hold,
    input  logic      flush,
    input  logic      retire_valid,
    input  reg_addr_t retire_rd_addr,
    input  word_t     retire_rd_data,
    input  pc_t       next_pc,
    input  logic      change_pc,
    input  logic      flush_out,
    input  reg_addr_t rs1_addr,
    input  word_t     rs1_data,
    input  reg_addr_t rs2_addr,
    input  word_t     rs2_data,
    input  logic      readout,
    output int        tests,
    output int        errors,
    output int        pending
);

    logic [7:0] mem_model [1024];
    word_t      reg_model [32];

    // in-flight instructions with the oldest at the front.
    reg_addr_t  q_rd [$];
    word_t      q_data [$];
    logic       q_we [$];
    pc_t        q_pc [$];
    logic       q_cpc [$];
    int         q_cycle [$];

    int         cycle;
    int         last_hold;
    logic       prev_flush;
    logic       st_pend;
    funct_t     st_funct;
    word_t      st_addr;
    word_t      st_data;

    initial begin
        tests     = 0;
        errors    = 0;
        pending   = 0;
        cycle     = 0;
        last_hold = -1;
        for (int i = 0; i < 1024; i++) begin
            mem_model[i] = 8'h00;
        end
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
    end

    function automatic word_t load_value(funct_t f, word_t a);
        logic [9:0] i;
        i = a[9:0];
        case (f)
            F3_B:    load_value = {{24{mem_model[i][7]}}, mem_model[i]};
            F3_BU:   load_value = {24'd0, mem_model[i]};
            F3_H:    load_value = {{16{mem_model[i+1][7]}}, mem_model[i+1], mem_model[i]};
            F3_HU:   load_value = {16'd0, mem_model[i+1], mem_model[i]};
            default: load_value = {mem_model[i+3], mem_model[i+2], mem_model[i+1], mem_model[i]};
        endcase
    endfunction

    task automatic store_bytes(input funct_t f, input word_t a, input word_t d);
        int n;
        logic [9:0] i;
        i = a[9:0];
        n = (f == F3_B) ? 1 : (f == F3_H) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            mem_model[i + b] = d[8*b +: 8];
        end
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp,
                                output bit ok);
        ok = (got === exp);
        if (!ok) begin
            errors++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge wb_clk) begin
        bit    ok;
        bit    ok2;
        bit    all_ok;
        word_t exp;
        if (!wb_rst) begin
            q_rd.delete();
            q_data.delete();
            q_we.delete();
            q_pc.delete();
            q_cpc.delete();
            q_cycle.delete();
            st_pend    = 1'b0;
            prev_flush = 1'b0;
        end else begin
            cycle++;
            if (hold) begin
                last_hold = cycle;
            end
            compare_word("flush_out", {31'd0, flush_out}, {31'd0, prev_flush}, ok);
            prev_flush = flush;
            compare_word("rs1_data", rs1_data, reg_model[rs1_addr], ok);
            compare_word("rs2_data", rs2_data, reg_model[rs2_addr], ok2);
            if (readout) begin
                tests++;
                $display("readout x%0d = %h x%0d = %h %s", rs1_addr, rs1_data,
                         rs2_addr, rs2_data, (ok && ok2) ? "ok" : "mismatch");
            end

            // --------------------
            // retire side.
            // --------------------
            if (retire_valid && !flush) begin
                if (q_rd.size() == 0) begin
                    errors++;
                    $display("retire at %0t with no instruction in flight", $time);
                end else begin
                    all_ok = 1'b1;
                    compare_word("retire_rd_addr", {27'd0, retire_rd_addr}, {27'd0, q_rd[0]}, ok);
                    all_ok &= ok;
                    compare_word("retire_rd_data", retire_rd_data, q_data[0], ok);
                    all_ok &= ok;
                    compare_word("next_pc", next_pc, q_pc[0] + 32'd4, ok);
                    all_ok &= ok;
                    compare_word("change_pc", {31'd0, change_pc}, {31'd0, q_cpc[0]}, ok);
                    all_ok &= ok;
                    if (!hold) begin
                        tests++;
                        if (last_hold < q_cycle[0] && cycle - q_cycle[0] != 3) begin
                            errors++;
                            all_ok = 1'b0;
                            $display("retire of pc %h took %0d cycles instead of 3",
                                     q_pc[0], cycle - q_cycle[0]);
                        end
                        if (q_we[0] && q_rd[0] != 5'd0) begin
                            reg_model[q_rd[0]] = q_data[0];
                        end
                        $display("retire pc %h rd x%0d data %h %s", q_pc[0], q_rd[0],
                                 q_data[0], all_ok ? "ok" : "mismatch");
                        void'(q_rd.pop_front());
                        void'(q_data.pop_front());
                        void'(q_we.pop_front());
                        void'(q_pc.pop_front());
                        void'(q_cpc.pop_front());
                        void'(q_cycle.pop_front());
                    end
                end
            end

            // a store reaches the RAM one edge after acceptance unless flushed.
            if (st_pend && !flush) begin
                store_bytes(st_funct, st_addr, st_data);
            end
            st_pend = 1'b0;

            if (flush) begin
                q_rd.delete();
                q_data.delete();
                q_we.delete();
                q_pc.delete();
                q_cpc.delete();
                q_cycle.delete();
            end

            if (ex_valid && ex_ready) begin
                if (ex_opcode[OP_LOAD]) begin
                    exp = load_value(ex_funct, ex_result);
                end else if (ex_we_rd) begin
                    exp = ex_result;
                end else begin
                    exp = '0;
                end
                q_rd.push_back(ex_rd_addr);
                q_data.push_back(exp);
                q_we.push_back(ex_we_rd);
                q_pc.push_back(ex_pc);
                q_cpc.push_back(ex_change_pc);
                q_cycle.push_back(cycle);
                if (ex_opcode[OP_STORE]) begin
                    st_pend  = 1'b1;
                    st_funct = ex_funct;
                    st_addr  = ex_result;
                    st_data  = ex_store_data;
                end
            end
        end
        pending = q_rd.size();
    end

endmodule

/* tb_rv_tail.sv */
`timescale 1ns/1ps

module tb_rv_tail import rv_tail_pkg::*;;

    localparam int K_ALU   = 0;
    localparam int K_STORE = 1;
    localparam int K_LOAD  = 2;
    localparam int K_FLUSH = 3;
    localparam int K_HOLD  = 4;

    logic      wb_clk;
    logic      wb_rst;
    logic      ex_valid;
    logic      ex_ready;
    opcode_t   ex_opcode;
    funct_t    ex_funct;
    reg_addr_t ex_rd_addr;
    logic      ex_we_rd;
    word_t     ex_result;
    word_t     ex_store_data;
    pc_t       ex_pc;
    logic      ex_change_pc;
    logic      hold;
    logic      flush;
    logic      retire_valid;
    reg_addr_t retire_rd_addr;
    word_t     retire_rd_data;
    pc_t       next_pc;
    logic      change_pc;
    logic      flush_out;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      readout;
    int        tests;
    int        errors;
    int        pending;

    // stimulus table; for hold rows the value column is the delay before hold.
    int        t_kind [$];
    funct_t    t_funct [$];
    reg_addr_t t_rd [$];
    logic      t_we [$];
    word_t     t_val [$];
    word_t     t_sdata [$];
    pc_t       t_pc [$];
    logic      t_cpc [$];

    int        seed = 32'h67e4_db3c;
    bit        timed_out;

    rv_tail_top #(.RAM_WORDS(256), .RAM_AW(8)) dut_i (.*);

    tb_checker check_i (.*);

    initial begin
        wb_clk = 1'b0;
        forever #50 wb_clk = ~wb_clk;
    end

    task automatic add_row(input int kind, input funct_t f, input reg_addr_t rd,
                           input logic we, input word_t val, input word_t sdata,
                           input logic cpc);
        t_kind.push_back(kind);
        t_funct.push_back(f);
        t_rd.push_back(rd);
        t_we.push_back(we);
        t_val.push_back(val);
        t_sdata.push_back(sdata);
        t_pc.push_back(32'h100 + 4 * t_kind.size());
        t_cpc.push_back(cpc);
    endtask

    function automatic opcode_t opcode_for(int kind);
        opcode_t o;
        o = '0;
        case (kind)
            K_STORE: o[OP_STORE] = 1'b1;
            K_LOAD:  o[OP_LOAD]  = 1'b1;
            default: o[OP_ITYPE] = 1'b1;
        endcase
        return o;
    endfunction

    // starts and ends on a falling edge.
    task automatic issue_row(input int i);
        int waited;
        ex_opcode     = opcode_for(t_kind[i]);
        ex_funct      = t_funct[i];
        ex_rd_addr    = t_rd[i];
        ex_we_rd      = t_we[i];
        ex_result     = t_val[i];
        ex_store_data = t_sdata[i];
        ex_pc         = t_pc[i];
        ex_change_pc  = t_cpc[i];
        ex_valid      = 1'b1;
        #1;
        waited = 0;
        while (!ex_ready && !timed_out) begin
            @(negedge wb_clk);
            #1;
            waited++;
            if (waited > 40) begin
                timed_out = 1'b1;
                $display("timeout: ex_ready stayed low for row %0d", i);
            end
        end
        if (!timed_out) begin
            @(posedge wb_clk);
        end
        @(negedge wb_clk);
        ex_valid = 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (pending != 0 && !timed_out) begin
            @(negedge wb_clk);
            waited++;
            if (waited > 100) begin
                timed_out = 1'b1;
                $display("timeout: %0d instructions never retired", pending);
            end
        end
    endtask

    initial begin
        int n;
        wb_rst        = 1'b0;
        ex_valid      = 1'b0;
        ex_opcode     = '0;
        ex_funct      = '0;
        ex_rd_addr    = '0;
        ex_we_rd      = 1'b0;
        ex_result     = '0;
        ex_store_data = '0;
        ex_pc         = '0;
        ex_change_pc  = 1'b0;
        hold          = 1'b0;
        flush         = 1'b0;
        rs1_addr      = '0;
        rs2_addr      = '0;
        readout       = 1'b0;
        timed_out     = 1'b0;

        // --------------------
        // stimulus table.
        // --------------------
        add_row(K_ALU,   F3_W,  5'd5,  1, 32'h1234_5678, 0, 0);
        add_row(K_ALU,   F3_W,  5'd6,  0, 32'hdead_beef, 0, 0);
        add_row(K_ALU,   F3_W,  5'd0,  1, 32'hffff_ffff, 0, 0);
        add_row(K_ALU,   F3_W,  5'd7,  1, 32'h0000_0042, 0, 1);
        add_row(K_HOLD,  F3_W,  5'd0,  0, 2, 0, 0);
        add_row(K_STORE, F3_W,  5'd0,  0, 32'h40, 32'h8765_4321, 0);
        add_row(K_STORE, F3_W,  5'd0,  0, 32'h44, 32'h0000_0000, 0);
        add_row(K_STORE, F3_B,  5'd0,  0, 32'h41, 32'h0000_00a5, 0);
        add_row(K_STORE, F3_H,  5'd0,  0, 32'h46, 32'h0000_80f1, 0);
        add_row(K_LOAD,  F3_W,  5'd8,  1, 32'h40, 0, 0);
        add_row(K_LOAD,  F3_B,  5'd9,  1, 32'h41, 0, 0);
        add_row(K_HOLD,  F3_W,  5'd0,  0, 0, 0, 0);
        add_row(K_LOAD,  F3_BU, 5'd10, 1, 32'h41, 0, 0);
        add_row(K_LOAD,  F3_H,  5'd11, 1, 32'h46, 0, 0);
        add_row(K_LOAD,  F3_HU, 5'd12, 1, 32'h46, 0, 0);
        add_row(K_HOLD,  F3_W,  5'd0,  0, 2, 0, 0);
        add_row(K_LOAD,  F3_B,  5'd13, 1, 32'h43, 0, 0);
        add_row(K_LOAD,  F3_HU, 5'd14, 1, 32'h42, 0, 0);
        add_row(K_ALU,   F3_W,  5'd15, 1, 32'h0bad_cafe, 0, 1);
        add_row(K_STORE, F3_W,  5'd0,  0, 32'h44, 32'hffff_ffff, 0);
        add_row(K_FLUSH, F3_W,  5'd0,  0, 0, 0, 0);
        add_row(K_LOAD,  F3_W,  5'd16, 1, 32'h44, 0, 0);
        add_row(K_ALU,   F3_W,  5'd17, 1, 32'h1111_1111, 0, 0);
        add_row(K_FLUSH, F3_W,  5'd0,  0, 0, 0, 0);
        add_row(K_ALU,   F3_W,  5'd18, 1, 32'h2222_2222, 0, 0);
        add_row(K_HOLD,  F3_W,  5'd0,  0, 2, 0, 0);
        add_row(K_FLUSH, F3_W,  5'd0,  0, 0, 0, 0);
        add_row(K_LOAD,  F3_W,  5'd19, 1, 32'h44, 0, 0);
        add_row(K_ALU,   F3_W,  5'd20, 1, 32'h3333_3333, 0, 0);
        add_row(K_ALU,   F3_W,  5'd0,  1, 32'h4444_4444, 0, 0);

        repeat (8) @(posedge wb_clk);
        @(negedge wb_clk);
        wb_rst = 1'b1;
        @(negedge wb_clk);

        for (int i = 0; i < t_kind.size() && !timed_out; i++) begin
            case (t_kind[i])
                K_HOLD: begin
                    n = 1 + ({$random(seed)} % 6);
                    repeat (t_val[i]) @(negedge wb_clk);
                    hold = 1'b1;
                    repeat (n) @(negedge wb_clk);
                    hold = 1'b0;
                end
                K_FLUSH: begin
                    flush = 1'b1;
                    @(negedge wb_clk);
                    flush = 1'b0;
                end
                default: issue_row(i);
            endcase
        end
        drain_pipeline();

        // read every register back through both ports.
        for (int r = 0; r < 32 && !timed_out; r++) begin
            rs1_addr = reg_addr_t'(r);
            rs2_addr = reg_addr_t'(31 - r);
            readout  = 1'b1;
            @(negedge wb_clk);
        end
        readout = 1'b0;
        @(negedge wb_clk);

        $display("tests %0d, errors %0d", tests, errors);
        if (!timed_out && errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* write_back.sv */
`timescale 1ns/1ps

module write_back import rv_tail_pkg::*; (
    input  logic      wb_clk,
    input  logic      wb_rst,
    input  logic      mem_ce,
    output logic      wb_stall,
    input  opcode_t   mem_opcode,
    input  funct_t    mem_funct,
    input  reg_addr_t mem_rd_addr,
    input  logic      mem_we_rd,
    input  word_t     mem_rd_data,
    input  pc_t       mem_pc,
    input  logic      mem_change_pc,
    input  word_t     mem_load_data,
    input  logic      hold,
    input  logic      flush,
    output logic      retire_valid,
    output reg_addr_t retire_rd_addr,
    output word_t     retire_rd_data,
    output pc_t       next_pc,
    output logic      change_pc,
    output logic      flush_out,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata
);

    logic  accept;
    logic  retire_we;
    word_t wdata_sel;

    assign wb_stall = hold;
    assign accept   = mem_ce && !hold && !flush;

    always_comb begin
        if (mem_opcode[OP_LOAD]) begin
            wdata_sel = mem_load_data;
        end else if (mem_we_rd) begin
            wdata_sel = mem_rd_data;
        end else begin
            wdata_sel = '0;
        end
    end

    always_ff @(posedge wb_clk or negedge wb_rst) begin
        if (!wb_rst) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
            change_pc    <= 1'b0;
            flush_out    <= 1'b0;
            next_pc      <= '0;
        end else begin
            flush_out <= flush;
            if (flush) begin
                retire_valid <= 1'b0;
                retire_we    <= 1'b0;
                change_pc    <= 1'b0;
            end else if (!hold) begin
                retire_valid <= mem_ce;
                retire_we    <= mem_ce && mem_we_rd;
                change_pc    <= mem_ce && mem_change_pc;
                if (mem_ce) begin
                    next_pc <= mem_pc + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge wb_clk) begin
        if (accept) begin
            retire_rd_addr <= mem_rd_addr;
            retire_rd_data <= wdata_sel;
        end
    end

    // the result commits on the edge that ends the retire cycle.
    assign rf_we    = retire_valid && retire_we && !hold && !flush;
    assign rf_waddr = retire_rd_addr;
    assign rf_wdata = retire_rd_data;

    a_flush_kill: assert property (@(posedge wb_clk) disable iff (!wb_rst)
        flush |=> !retire_valid)
        else $error("write_back: retire_valid high after flush");

endmodule
